// File: common/spi_pkg.sv
package spi_pkg;

    // Array size and SCLK timing
    localparam int num_chan  = 4;
    localparam int sclk_half = 8;  // clk cycles per SCLK half period
    localparam int byte_bits = 8;  // Bits per transfer, MSB first

    typedef logic [7:0]  spi_byte_t;
    typedef logic [1:0]  chan_idx_t;
    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;
    typedef logic [3:0]  bit_cnt_t;
    typedef logic [3:0]  div_cnt_t;

    // Register offsets inside each 16-byte channel window
    localparam apb_addr_t reg_tx     = 8'h00;
    localparam apb_addr_t reg_rx     = 8'h04;
    localparam apb_addr_t reg_status = 8'h08;

    // STATUS register bit positions
    localparam int stat_busy    = 0;
    localparam int stat_valid   = 1;
    localparam int stat_overrun = 2;

    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_req_t;

    typedef struct packed {
        apb_data_t prdata;
        logic      pready;
        logic      pslverr;
    } apb_rsp_t;

    // Outgoing pins of one channel
    typedef struct packed {
        logic sclk;
        logic mosi;
        logic cs_n;
    } spi_pins_t;

    typedef enum logic [1:0] {
        idle,
        shift,
        finish
    } engine_state_t;

endpackage

// File: spi_engine/spi_engine.sv
`timescale 1ns/10ps

module spi_engine (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  spi_pkg::spi_byte_t tx_byte,
    input  logic               miso,
    output spi_pkg::spi_pins_t pins,
    output logic               busy,
    output logic               done,
    output spi_pkg::spi_byte_t rx_byte
);
    import spi_pkg::*;

    localparam div_cnt_t div_last = div_cnt_t'(sclk_half - 1);
    localparam bit_cnt_t bit_last = bit_cnt_t'(byte_bits - 1);

    engine_state_t state;
    div_cnt_t      div_cnt;
    bit_cnt_t      bit_cnt;
    spi_byte_t     tx_shift;
    spi_byte_t     rx_shift;
    logic          accept;     // Start taken in idle
    logic          half_end;   // Last clk of an SCLK half period
    logic          rise_edge;
    logic          fall_edge;
    logic          last_fall;  // Falling edge of bit 0

    assign accept    = (state == idle) && start;
    assign half_end  = (state == shift) && (div_cnt == div_last);
    assign rise_edge = half_end && !pins.sclk;
    assign fall_edge = half_end && pins.sclk;
    assign last_fall = fall_edge && (bit_cnt == bit_last);

    // Divider only runs while shifting, so the first half period is a full one
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
        end else if ((state != shift) || half_end) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // Control FSM, bits counted on falling SCLK
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= idle;
            bit_cnt <= '0;
        end else begin
            case (state)
                idle: begin
                    if (start) begin
                        state   <= shift;
                        bit_cnt <= '0;
                    end
                end
                shift: begin
                    if (fall_edge) begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                    if (last_fall) begin
                        state <= finish;
                    end
                end
                finish: state <= idle;  // One-cycle done slot
                default: state <= idle;
            endcase
        end
    end

    // Pin registers
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pins.sclk <= 1'b0;
            pins.mosi <= 1'b0;
            pins.cs_n <= 1'b1;
        end else begin
            if (accept) begin
                pins.cs_n <= 1'b0;  // Select one cycle after start
            end
            if (half_end) begin
                pins.sclk <= ~pins.sclk;
            end
            if (rise_edge) begin
                pins.mosi <= tx_shift[byte_bits-1];  // Mode 1 launches on the rising edge
            end
            if (last_fall) begin
                pins.cs_n <= 1'b1;  // Deselect together with done
                pins.mosi <= 1'b0;
            end
        end
    end

    // Data shifters
    always_ff @(posedge clk) begin
        if (accept) begin
            tx_shift <= tx_byte;
        end else if (rise_edge) begin
            tx_shift <= {tx_shift[byte_bits-2:0], 1'b0};
        end
        if (fall_edge) begin
            rx_shift <= {rx_shift[byte_bits-2:0], miso};  // MISO settled since the rise
        end
    end

    assign busy    = (state != idle) || start;
    assign done    = (state == finish);
    assign rx_byte = rx_shift;  // Complete in the done cycle

endmodule

// File: hw/apb_spi_regs.sv
`timescale 1ns/10ps

module apb_spi_regs (
    input  logic                         clk,
    input  logic                         rst,
    input  spi_pkg::apb_req_t            req,
    output spi_pkg::apb_rsp_t            rsp,
    input  logic [spi_pkg::num_chan-1:0] busy,
    input  spi_pkg::spi_byte_t           rx_data [spi_pkg::num_chan],
    input  logic [spi_pkg::num_chan-1:0] rx_valid,
    input  logic [spi_pkg::num_chan-1:0] overrun,
    output logic [spi_pkg::num_chan-1:0] start,
    output spi_pkg::spi_byte_t           tx_byte [spi_pkg::num_chan],
    output logic [spi_pkg::num_chan-1:0] rd_clear
);
    import spi_pkg::*;

    logic [3:0] win;          // Channel window number
    chan_idx_t  chan;
    apb_addr_t  offset;
    logic       in_range;
    logic       hit_tx;
    logic       hit_rx;
    logic       hit_status;
    logic       mapped;
    logic       first_cycle;  // First access cycle, the wait state
    logic       tx_ok;
    logic       ready_q;
    logic       err_q;
    apb_data_t  rdata;

    // Address decode
    assign win      = req.paddr[7:4];
    assign in_range = (win < num_chan);
    assign chan     = chan_idx_t'(win);
    assign offset   = {4'h0, req.paddr[3:0]};

    assign hit_tx     = in_range && (offset == reg_tx);
    assign hit_rx     = in_range && (offset == reg_rx);
    assign hit_status = in_range && (offset == reg_status);
    assign mapped     = hit_tx || hit_rx || hit_status;

    assign first_cycle = req.psel && req.penable && !ready_q;
    assign tx_ok       = first_cycle && req.pwrite && hit_tx && !busy[chan];

    // Decisions are made in the wait state and show up in the completing cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ready_q  <= 1'b0;
            err_q    <= 1'b0;
            start    <= '0;
            rd_clear <= '0;
        end else begin
            ready_q  <= first_cycle;
            err_q    <= 1'b0;
            start    <= '0;
            rd_clear <= '0;
            if (first_cycle) begin
                if (!mapped) begin
                    err_q <= 1'b1;
                end else if (req.pwrite && hit_tx) begin
                    if (busy[chan]) begin
                        err_q <= 1'b1;  // Channel still shifting, byte dropped
                    end else begin
                        start[chan] <= 1'b1;
                    end
                end else if (!req.pwrite && hit_rx) begin
                    rd_clear[chan] <= 1'b1;
                end
            end
        end
    end

    // Transmit byte held for the engine
    always_ff @(posedge clk) begin
        if (tx_ok) begin
            tx_byte[chan] <= req.pwdata[7:0];
        end
    end

    // Read data is taken live in the completing cycle, so a byte landing
    // during the wait state is not lost
    always_comb begin
        rdata = '0;
        if (!req.pwrite) begin
            if (hit_tx) begin
                rdata = apb_data_t'(tx_byte[chan]);
            end else if (hit_rx) begin
                rdata = apb_data_t'(rx_data[chan]);
            end else if (hit_status) begin
                rdata[stat_busy]    = busy[chan];
                rdata[stat_valid]   = rx_valid[chan];
                rdata[stat_overrun] = overrun[chan];
            end
        end
    end

    assign rsp.prdata  = ready_q ? rdata : '0;
    assign rsp.pready  = ready_q;
    assign rsp.pslverr = err_q;

endmodule

// File: hw/spi_rx_collect.sv
`timescale 1ns/10ps

module spi_rx_collect (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [spi_pkg::num_chan-1:0] done,
    input  spi_pkg::spi_byte_t           rx_byte [spi_pkg::num_chan],
    input  logic [spi_pkg::num_chan-1:0] rd_clear,
    output spi_pkg::spi_byte_t           rx_data [spi_pkg::num_chan],
    output logic [spi_pkg::num_chan-1:0] rx_valid,
    output logic [spi_pkg::num_chan-1:0] overrun
);
    import spi_pkg::*;

    // Flags per channel
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rx_valid <= '0;
            overrun  <= '0;
        end else begin
            for (int i = 0; i < num_chan; i++) begin
                if (done[i]) begin
                    rx_valid[i] <= 1'b1;
                    // A byte read in this same cycle is not overrun
                    overrun[i]  <= !rd_clear[i] && (overrun[i] || rx_valid[i]);
                end else if (rd_clear[i]) begin
                    rx_valid[i] <= 1'b0;
                    overrun[i]  <= 1'b0;
                end
            end
        end
    end

    // Newest byte always overwrites the held one
    always_ff @(posedge clk) begin
        for (int i = 0; i < num_chan; i++) begin
            if (done[i]) begin
                rx_data[i] <= rx_byte[i];
            end
        end
    end

endmodule

// File: hw/spi_array_top.sv
`timescale 1ns/10ps

module spi_array_top (
    input  logic                         clk,
    input  logic                         rst,
    input  spi_pkg::apb_req_t            apb_req,
    output spi_pkg::apb_rsp_t            apb_rsp,
    input  logic [spi_pkg::num_chan-1:0] miso,
    output spi_pkg::spi_pins_t           spi [spi_pkg::num_chan]
);
    import spi_pkg::*;

    logic [num_chan-1:0] start;
    logic [num_chan-1:0] busy;
    logic [num_chan-1:0] done;
    logic [num_chan-1:0] rd_clear;
    logic [num_chan-1:0] rx_valid;
    logic [num_chan-1:0] overrun;
    spi_byte_t           tx_byte [num_chan];
    spi_byte_t           eng_rx  [num_chan];  // Straight from the shifters
    spi_byte_t           rx_data [num_chan];  // Held for the host

    apb_spi_regs u_regs (
        .clk      (clk),
        .rst      (rst),
        .req      (apb_req),
        .rsp      (apb_rsp),
        .busy     (busy),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .overrun  (overrun),
        .start    (start),
        .tx_byte  (tx_byte),
        .rd_clear (rd_clear)
    );

    for (genvar i = 0; i < num_chan; i++) begin : g_chan
        spi_engine u_engine (
            .clk     (clk),
            .rst     (rst),
            .start   (start[i]),
            .tx_byte (tx_byte[i]),
            .miso    (miso[i]),
            .pins    (spi[i]),
            .busy    (busy[i]),
            .done    (done[i]),
            .rx_byte (eng_rx[i])
        );
    end

    spi_rx_collect u_collect (
        .clk      (clk),
        .rst      (rst),
        .done     (done),
        .rx_byte  (eng_rx),
        .rd_clear (rd_clear),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .overrun  (overrun)
    );

endmodule

// File: dv/spi_slave_model.sv
`timescale 1ns/10ps

module spi_slave_model (
    input  logic               sclk,
    input  logic               mosi,
    input  logic               cs_n,
    input  spi_pkg::spi_byte_t resp_byte,  // Byte sent back on MISO
    output logic               miso,
    output spi_pkg::spi_byte_t captured,   // Last byte seen on MOSI
    output int unsigned        byte_count
);
    import spi_pkg::*;

    spi_byte_t rx_shift;
    logic      mosi_hold;  // MOSI taken just after the rising edge

    // Mode 1 slave, one byte per select
    initial begin
        miso       = 1'b0;
        captured   = '0;
        byte_count = 0;
        rx_shift   = '0;
        mosi_hold  = 1'b0;
        forever begin
            @(negedge cs_n);
            miso = resp_byte[byte_bits-1];  // MSB out as soon as selected
            for (int b = 0; b < byte_bits; b++) begin
                @(posedge sclk);
                miso = resp_byte[byte_bits-1-b];
                // Master launches MOSI on this same edge
                #1;
                mosi_hold = mosi;
                @(negedge sclk);
                rx_shift = {rx_shift[byte_bits-2:0], mosi_hold};  // Sample point
            end
            captured   = rx_shift;
            byte_count = byte_count + 1;  // Tells the testbench a byte is in
        end
    end

endmodule

// File: dv/tb_spi_array.sv
`timescale 1ns/10ps

module tb_spi_array;
    import spi_pkg::*;

    localparam int clk_period      = 100;
    localparam int drive_delay     = 10;
    localparam int max_transfers   = 40;
    localparam int transfer_cycles = 300;
    localparam int poll_limit      = 200;  // STATUS reads before giving up on a channel

    logic                clk;
    logic                rst;
    apb_req_t            apb_req;
    apb_rsp_t            apb_rsp;
    logic [num_chan-1:0] miso;
    spi_pins_t           spi        [num_chan];
    spi_byte_t           resp       [num_chan];  // Slave reply per channel
    spi_byte_t           captured   [num_chan];
    int unsigned         byte_count [num_chan];
    spi_byte_t           exp_tx     [num_chan];  // Last accepted TX byte
    int unsigned         seed_ret;

    spi_array_top uut (
        .clk     (clk),
        .rst     (rst),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .miso    (miso),
        .spi     (spi)
    );

    for (genvar i = 0; i < num_chan; i++) begin : g_slave
        spi_slave_model u_slave (
            .sclk       (spi[i].sclk),
            .mosi       (spi[i].mosi),
            .cs_n       (spi[i].cs_n),
            .resp_byte  (resp[i]),
            .miso       (miso[i]),
            .captured   (captured[i]),
            .byte_count (byte_count[i])
        );

        // Every byte on MOSI must be the last accepted TX write
        always @(byte_count[i]) begin
            if (byte_count[i] != 0) begin
                expect_equal($sformatf("MOSI byte on channel %0d", i), captured[i], exp_tx[i]);
            end
        end
    end

    // Expected slave reply is the inverted TX byte XOR channel times 0x11
    function automatic spi_byte_t slave_reply(int ch, spi_byte_t tx);
        return ~tx ^ spi_byte_t'(ch * 8'h11);
    endfunction

    task automatic abort_run(string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic expect_equal(string what, int got, int exp);
        assert (got == exp) else begin
            abort_run($sformatf("FAILED at %0d ns: %s is 0x%0h, expected 0x%0h",
                                $time, what, got, exp));
        end
    endtask

    // One APB transfer entered and left 10 ns after a rising edge
    task automatic apb_access(input logic write, input apb_addr_t addr, input apb_data_t wdata,
                              output apb_data_t rdata, output logic err);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(posedge clk);
        #drive_delay;
        apb_req.penable = 1'b1;
        @(negedge clk);
        while (!apb_rsp.pready) @(negedge clk);
        rdata = apb_rsp.prdata;  // Mid-cycle, well away from the edges
        err   = apb_rsp.pslverr;
        @(posedge clk);
        #drive_delay;
        apb_req = '0;
    endtask

    task automatic reg_write(int ch, apb_addr_t off, apb_data_t data, output logic err);
        apb_data_t unused;
        apb_access(1'b1, apb_addr_t'(ch * 16) + off, data, unused, err);
    endtask

    task automatic reg_read(int ch, apb_addr_t off, output apb_data_t data, output logic err);
        apb_access(1'b0, apb_addr_t'(ch * 16) + off, '0, data, err);
    endtask

    task automatic start_transfer(int ch, spi_byte_t tx);
        logic err;
        resp[ch]   = slave_reply(ch, tx);
        exp_tx[ch] = tx;
        reg_write(ch, reg_tx, apb_data_t'(tx), err);
        expect_equal($sformatf("TX write error on channel %0d", ch), err, 0);
    endtask

    // Poll STATUS until busy is clear and a byte is waiting
    task automatic wait_result(int ch);
        apb_data_t st;
        logic      err;
        int        polls;
        st    = '0;
        polls = 0;
        while (st[stat_busy] || !st[stat_valid]) begin
            if (polls == poll_limit) begin
                abort_run($sformatf("Channel %0d never finished its transfer", ch));
            end else begin
                reg_read(ch, reg_status, st, err);
                polls++;
            end
        end
    endtask

    task automatic check_rx(int ch, spi_byte_t tx);
        apb_data_t data;
        logic      err;
        reg_read(ch, reg_rx, data, err);
        expect_equal($sformatf("RX read on channel %0d", ch), data, slave_reply(ch, tx));
        expect_equal($sformatf("RX read error on channel %0d", ch), err, 0);
    endtask

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(max_transfers * transfer_cycles * clk_period);
        abort_run("Timeout: the tests did not finish in the allowed time");
    end

    initial begin
        spi_byte_t tx [num_chan];
        spi_byte_t first_tx;
        spi_byte_t second_tx;
        apb_data_t data;
        logic      err;
        seed_ret = $urandom(32'hdbb3cfcc);
        rst      = 1'b1;
        apb_req  = '0;
        for (int ch = 0; ch < num_chan; ch++) begin
            resp[ch]   = '0;
            exp_tx[ch] = '0;
        end
        repeat (5) @(posedge clk);
        #drive_delay;
        rst = 1'b0;

        // Idle pins and clear STATUS out of reset
        for (int ch = 0; ch < num_chan; ch++) begin
            expect_equal($sformatf("cs_n after reset on channel %0d", ch), spi[ch].cs_n, 1);
            expect_equal($sformatf("sclk after reset on channel %0d", ch), spi[ch].sclk, 0);
            reg_read(ch, reg_status, data, err);
            expect_equal($sformatf("STATUS after reset on channel %0d", ch), data, 0);
        end

        // Random bytes on one channel at a time
        for (int round = 0; round < 3; round++) begin
            for (int ch = 0; ch < num_chan; ch++) begin
                first_tx = spi_byte_t'($urandom);
                start_transfer(ch, first_tx);
                wait_result(ch);
                check_rx(ch, first_tx);
            end
        end

        // All channels in flight together
        for (int ch = 0; ch < num_chan; ch++) begin
            tx[ch] = spi_byte_t'($urandom);
            start_transfer(ch, tx[ch]);
        end
        @(posedge clk);
        #drive_delay;
        for (int ch = 0; ch < num_chan; ch++) begin
            expect_equal($sformatf("cs_n with all channels running, ch %0d", ch), spi[ch].cs_n, 0);
        end
        for (int ch = 0; ch < num_chan; ch++) begin
            wait_result(ch);
            check_rx(ch, tx[ch]);
        end

        // TX write to a busy channel is refused
        first_tx  = spi_byte_t'($urandom);
        second_tx = ~first_tx;
        start_transfer(1, first_tx);
        reg_write(1, reg_tx, apb_data_t'(second_tx), err);
        expect_equal("pslverr on TX write to busy channel 1", err, 1);
        wait_result(1);
        check_rx(1, first_tx);

        // Two results without a read in between
        start_transfer(2, first_tx);
        wait_result(2);
        start_transfer(2, second_tx);
        wait_result(2);
        reg_read(2, reg_status, data, err);
        expect_equal("STATUS with overrun on channel 2", data, 6);
        check_rx(2, second_tx);
        reg_read(2, reg_status, data, err);
        expect_equal("STATUS after RX read on channel 2", data, 0);

        // Unmapped offsets and windows
        reg_read(0, 8'h0c, data, err);
        expect_equal("read data at offset 0x0c", data, 0);
        expect_equal("pslverr on read at offset 0x0c", err, 1);
        reg_read(num_chan, 8'h00, data, err);
        expect_equal("read data past the last channel", data, 0);
        expect_equal("pslverr on read past the last channel", err, 1);
        reg_write(0, 8'h0c, 32'h5a, err);
        expect_equal("pslverr on write at offset 0x0c", err, 1);

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: all.f
common/spi_pkg.sv
spi_engine/spi_engine.sv
hw/apb_spi_regs.sv
hw/spi_rx_collect.sv
hw/spi_array_top.sv
dv/spi_slave_model.sv
dv/tb_spi_array.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -Wno-fatal -j 0
TOP       ?= tb_spi_array
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := *** TEST PASSED ***

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM_BIN))"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
